//--- verilog/cache_pkg.sv
package cache_pkg;

  // Cache geometry
  localparam int NUM_LINES      = 4;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_BITS      = WORDS_PER_LINE * 32;
  localparam int TAG_WIDTH      = 28;

  // Backing memory
  localparam int MEM_LINES     = 256;
  localparam int MEM_LATENCY   = 4;
  localparam int MEM_IDX_WIDTH = $clog2(MEM_LINES);
  localparam int MEM_CNT_WIDTH = $clog2(MEM_LATENCY) + 1;

  typedef logic [1:0] line_idx_t;

  // Field view of a CPU address
  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic [1:0]           word_off;
    logic [1:0]           byte_off;
  } addr_fields_t;

  // Same word seen as raw bits or as tag and offsets
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t f;
  } cache_addr_u;

  typedef struct packed {
    logic        write;
    logic        byte_op;
    cache_addr_u addr;
    logic [31:0] wdata;
  } cpu_req_t;

  // Byte reads come back zero-extended
  typedef struct packed {
    logic [31:0] rdata;
  } cpu_resp_t;

  typedef struct packed {
    logic                 write;
    logic [TAG_WIDTH-1:0] line_addr;
    logic [LINE_BITS-1:0] data;
  } mem_req_t;

  // Stage 1 result, with the tag state stage 2 needs to pick a victim
  typedef struct packed {
    cpu_req_t                            req;
    logic                                hit;
    line_idx_t                           hit_line;
    logic [NUM_LINES-1:0]                dirty;
    logic [NUM_LINES-1:0][TAG_WIDTH-1:0] tags;
  } lookup_t;

  // Refill sets tag and valid; a write hit only sets dirty
  typedef struct packed {
    logic                 valid;
    line_idx_t            line;
    logic [TAG_WIDTH-1:0] tag;
    logic                 set_valid;
    logic                 set_dirty;
  } tag_update_t;

endpackage

//--- verilog/cache_lookup.sv
module cache_lookup (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cache_pkg::cpu_req_t    req,
  output logic                   req_ready,
  output logic                   lk_valid,
  output cache_pkg::lookup_t     lk,
  input  logic                   lk_take,
  input  cache_pkg::tag_update_t upd
);
  import cache_pkg::*;

  cpu_req_t                            rq_q;
  logic                                rq_valid_q;
  logic [NUM_LINES-1:0][TAG_WIDTH-1:0] tag_q;
  logic [NUM_LINES-1:0]                valid_q;
  logic [NUM_LINES-1:0]                dirty_q;
  logic [NUM_LINES-1:0]                hit_vec;
  line_idx_t                           hit_line;

  // Register frees up in the same cycle stage 2 takes it
  assign req_ready = !rq_valid_q || lk_take;
  assign lk_valid  = rq_valid_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      rq_valid_q <= 1'b0;
    else if (req_valid && req_ready)
      rq_valid_q <= 1'b1;
    else if (lk_take)
      rq_valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (req_valid && req_ready)
      rq_q <= req;
  end

  // One comparator per line
  always_comb
  begin
    for (int i = 0; i < NUM_LINES; i++)
      hit_vec[i] = valid_q[i] && (tag_q[i] == rq_q.addr.f.tag);
  end

  // Priority encoder, lowest matching line wins
  always_comb
  begin
    hit_line = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (hit_vec[i])
        hit_line = line_idx_t'(i);
    end
  end

  assign lk = '{req: rq_q, hit: |hit_vec, hit_line: hit_line, dirty: dirty_q, tags: tag_q};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else if (upd.valid)
    begin
      if (upd.set_valid)
      begin
        valid_q[upd.line] <= 1'b1;
        dirty_q[upd.line] <= upd.set_dirty;
      end
      else if (upd.set_dirty)
        dirty_q[upd.line] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (upd.valid && upd.set_valid)
      tag_q[upd.line] <= upd.tag;
  end

  // Refills always go to the victim, so a tag is never held twice
  a_single_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec));

endmodule

//--- verilog/cache_lru.sv
module cache_lru (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 touch_valid,
  input  cache_pkg::line_idx_t touch_line,
  output cache_pkg::line_idx_t victim
);
  import cache_pkg::*;

  // Age per line, 0 is least recently used
  line_idx_t            cnt_q [NUM_LINES];
  logic [NUM_LINES-1:0] seen;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_LINES; i++)
        cnt_q[i] <= line_idx_t'(i);
    end
    else if (touch_valid)
    begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
        if (line_idx_t'(i) == touch_line)
          cnt_q[i] <= line_idx_t'(NUM_LINES - 1);
        else if (cnt_q[i] >= cnt_q[touch_line])
          cnt_q[i] <= cnt_q[i] - 1'b1;
      end
    end
  end

  always_comb
  begin
    victim = '0;
    for (int i = 0; i < NUM_LINES; i++)
    begin
      if (cnt_q[i] == '0)
        victim = line_idx_t'(i);
    end
  end

  // Each age value held by exactly one line
  always_comb
  begin
    seen = '0;
    for (int i = 0; i < NUM_LINES; i++)
      seen[cnt_q[i]] = 1'b1;
  end

  a_lru_perm: assert property (@(posedge clk) disable iff (reset) &seen);

endmodule

//--- verilog/cache_access.sv
module cache_access (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            lk_valid,
  input  cache_pkg::lookup_t              lk,
  output logic                            lk_take,
  output cache_pkg::tag_update_t          upd,
  output logic                            touch_valid,
  output cache_pkg::line_idx_t            touch_line,
  input  cache_pkg::line_idx_t            victim,
  output logic                            resp_valid,
  output cache_pkg::cpu_resp_t            resp,
  output logic                            mem_req_valid,
  output cache_pkg::mem_req_t             mem_req,
  input  logic                            mem_ready,
  input  logic [cache_pkg::LINE_BITS-1:0] mem_rdata
);
  import cache_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_WB, ST_REFILL} state_t;

  state_t               state_q;
  line_idx_t            victim_q;
  logic [LINE_BITS-1:0] data_q [NUM_LINES];

  logic [TAG_WIDTH-1:0] req_tag;
  logic [6:0]           word_bit;
  logic [6:0]           byte_bit;
  logic [LINE_BITS-1:0] hit_data;
  logic [31:0]          rd_word;
  logic [7:0]           rd_byte;
  logic                 miss_start;
  logic                 wb_done;
  logic                 refill_done;

  // Bit positions of the addressed word and byte inside a line
  assign req_tag  = lk.req.addr.f.tag;
  assign word_bit = {lk.req.addr.f.word_off, 5'b00000};
  assign byte_bit = {lk.req.addr.f.word_off, lk.req.addr.f.byte_off, 3'b000};
  assign hit_data = data_q[lk.hit_line];
  assign rd_word  = hit_data[word_bit +: 32];
  assign rd_byte  = hit_data[byte_bit +: 8];

  // Misses stall stage 1 until the refilled line hits on replay
  assign lk_take     = lk_valid && lk.hit && (state_q == ST_IDLE);
  assign miss_start  = lk_valid && !lk.hit && (state_q == ST_IDLE);
  assign wb_done     = (state_q == ST_WB) && mem_ready;
  assign refill_done = (state_q == ST_REFILL) && mem_ready;

  assign touch_valid = lk_take;
  assign touch_line  = lk.hit_line;

  always_comb
  begin
    upd = '0;
    if (refill_done)
    begin
      upd.valid     = 1'b1;
      upd.line      = victim_q;
      upd.tag       = req_tag;
      upd.set_valid = 1'b1;
    end
    else if (lk_take && lk.req.write)
    begin
      upd.valid     = 1'b1;
      upd.line      = lk.hit_line;
      upd.tag       = req_tag;
      upd.set_dirty = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q       <= ST_IDLE;
      mem_req_valid <= 1'b0;
      resp_valid    <= 1'b0;
    end
    else
    begin
      resp_valid <= lk_take;
      case (state_q)
        ST_IDLE:
        begin
          if (miss_start)
          begin
            mem_req_valid <= 1'b1;
            state_q       <= lk.dirty[victim] ? ST_WB : ST_REFILL;
          end
        end
        ST_WB:
        begin
          // Request stays up, the refill read follows directly
          if (mem_ready)
            state_q <= ST_REFILL;
        end
        default:
        begin
          if (mem_ready)
          begin
            mem_req_valid <= 1'b0;
            state_q       <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (lk_take)
    begin
      if (lk.req.write)
        resp.rdata <= '0;
      else if (lk.req.byte_op)
        resp.rdata <= {24'd0, rd_byte};
      else
        resp.rdata <= rd_word;
    end

    if (lk_take && lk.req.write)
    begin
      if (lk.req.byte_op)
        data_q[lk.hit_line][byte_bit +: 8] <= lk.req.wdata[7:0];
      else
        data_q[lk.hit_line][word_bit +: 32] <= lk.req.wdata;
    end

    if (miss_start)
    begin
      victim_q          <= victim;
      mem_req.write     <= lk.dirty[victim];
      mem_req.line_addr <= lk.dirty[victim] ? lk.tags[victim] : req_tag;
      mem_req.data      <= data_q[victim];
    end

    if (wb_done)
    begin
      mem_req.write     <= 1'b0;
      mem_req.line_addr <= req_tag;
    end

    if (refill_done)
      data_q[victim_q] <= mem_rdata;
  end

  a_mem_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_ready |=> $stable(mem_req));

endmodule

//--- verilog/line_memory.sv
module line_memory (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            mem_req_valid,
  input  cache_pkg::mem_req_t             mem_req,
  output logic                            mem_ready,
  output logic [cache_pkg::LINE_BITS-1:0] mem_rdata
);
  import cache_pkg::*;

  logic [LINE_BITS-1:0]     mem_q [MEM_LINES] = '{default: '0};
  logic                     busy_q;
  logic [MEM_CNT_WIDTH-1:0] cnt_q;
  logic [MEM_IDX_WIDTH-1:0] idx;
  logic                     done;

  assign idx  = mem_req.line_addr[MEM_IDX_WIDTH-1:0];
  assign done = busy_q && (cnt_q == '0);

  // A new request starts only after the previous ready pulse is gone
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      mem_ready <= 1'b0;
    end
    else
    begin
      mem_ready <= 1'b0;
      if (busy_q)
      begin
        if (cnt_q == '0)
        begin
          busy_q    <= 1'b0;
          mem_ready <= 1'b1;
        end
        else
          cnt_q <= cnt_q - 1'b1;
      end
      else if (mem_req_valid && !mem_ready)
      begin
        busy_q <= 1'b1;
        // Ready lands MEM_LATENCY cycles after valid rises
        cnt_q  <= MEM_CNT_WIDTH'(MEM_LATENCY - 2);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (done)
    begin
      if (mem_req.write)
        mem_q[idx] <= mem_req.data;
      else
        mem_rdata <= mem_q[idx];
    end
  end

endmodule

//--- verilog/cache_top.sv
module cache_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  cache_pkg::cpu_req_t  req,
  output logic                 req_ready,
  output logic                 resp_valid,
  output cache_pkg::cpu_resp_t resp
);
  import cache_pkg::*;

  logic                 lk_valid;
  lookup_t              lk;
  logic                 lk_take;
  tag_update_t          upd;
  logic                 touch_valid;
  line_idx_t            touch_line;
  line_idx_t            victim;
  logic                 mem_req_valid;
  mem_req_t             mem_req;
  logic                 mem_ready;
  logic [LINE_BITS-1:0] mem_rdata;

  cache_lookup i_lookup (
    .clk, .reset, .req_valid, .req, .req_ready,
    .lk_valid, .lk, .lk_take, .upd
  );

  cache_lru i_lru (
    .clk, .reset, .touch_valid, .touch_line, .victim
  );

  cache_access i_access (
    .clk, .reset, .lk_valid, .lk, .lk_take, .upd,
    .touch_valid, .touch_line, .victim,
    .resp_valid, .resp,
    .mem_req_valid, .mem_req, .mem_ready, .mem_rdata
  );

  line_memory i_mem (
    .clk, .reset, .mem_req_valid, .mem_req, .mem_ready, .mem_rdata
  );

endmodule

//--- verif/cache_tb.sv
module cache_tb;
  import cache_pkg::*;

  localparam int          WAIT_LIMIT = 200;
  localparam logic [11:0] WIN_BASE   = 12'h300;

  logic      clk;
  logic      reset;
  logic      req_valid;
  cpu_req_t  req;
  logic      req_ready;
  logic      resp_valid;
  cpu_resp_t resp;

  // Flat byte model of the whole 4 KB address range
  logic [7:0]  ref_mem [4096];
  logic [31:0] lfsr;
  logic [31:0] exp_q [$];
  int          acc_q [$];
  int          cyc;
  int          checks;
  int          errors;
  int          last_checks;
  int          last_errors;
  logic        check_lat;
  logic        timed_out;

  cache_top i_dut (
    .clk, .reset, .req_valid, .req, .req_ready, .resp_valid, .resp
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Eight lines of 16 bytes starting at WIN_BASE
  function automatic logic [31:0] win_addr(input logic [2:0] line, input logic [1:0] word,
                                           input logic [1:0] byt);
    logic [11:0] off;
    off = WIN_BASE + {5'd0, line, word, byt};
    return {20'd0, off};
  endfunction

  // Applies a write to the model and returns the expected read data, little endian
  function automatic logic [31:0] model_apply(input logic wr, input logic bo,
                                              input logic [11:0] a, input logic [31:0] wd);
    logic [31:0] rd;
    logic [11:0] wa;
    rd = '0;
    wa = {a[11:2], 2'b00};
    if (wr && bo)
      ref_mem[a] = wd[7:0];
    else if (wr)
    begin
      for (int b = 0; b < 4; b++)
        ref_mem[wa + 12'(b)] = wd[8*b +: 8];
    end
    else if (bo)
      rd = {24'd0, ref_mem[a]};
    else
    begin
      for (int b = 0; b < 4; b++)
        rd[8*b +: 8] = ref_mem[wa + 12'(b)];
    end
    return rd;
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    timed_out = 1'b1;
  endtask

  // One clock; a response seen here was sampled high at the next edge
  task automatic step();
    logic [31:0] exp;
    int          acc;
    @(posedge clk);
    #1;
    cyc++;
    if (resp_valid)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("Response arrived with no request outstanding at t=%0t", $time);
      end
      else
      begin
        exp = exp_q.pop_front();
        acc = acc_q.pop_front();
        check("resp.rdata", resp.rdata, exp);
        if (check_lat)
          check("resp_latency", 32'(cyc + 1 - acc), 32'd2);
      end
    end
  endtask

  task automatic issue(input logic wr, input logic bo, input logic [31:0] addr,
                       input logic [31:0] wdata);
    int n;
    if (timed_out)
      return;
    req.write    = wr;
    req.byte_op  = bo;
    req.addr.raw = addr;
    req.wdata    = wdata;
    req_valid    = 1'b1;
    n = 0;
    while (!req_ready && n < WAIT_LIMIT)
    begin
      step();
      n++;
    end
    if (!req_ready)
    begin
      report_timeout("req_ready");
      return;
    end
    // Accepted at the coming edge
    exp_q.push_back(model_apply(wr, bo, addr[11:0], wdata));
    acc_q.push_back(cyc + 1);
    step();
  endtask

  task automatic drain();
    int n;
    if (timed_out)
      return;
    req_valid = 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT)
    begin
      step();
      n++;
    end
    if (exp_q.size() != 0)
      report_timeout("response");
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: %0d checks, %0d errors", num, name,
             checks - last_checks, errors - last_errors);
    last_checks = checks;
    last_errors = errors;
  endtask

  initial
  begin
    logic [31:0] op;
    logic [31:0] sub;
    logic [31:0] d;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    lfsr        = 32'h25b48b09;
    cyc         = 0;
    checks      = 0;
    errors      = 0;
    last_checks = 0;
    last_errors = 0;
    check_lat   = 1'b0;
    timed_out   = 1'b0;
    for (int i = 0; i < 4096; i++)
      ref_mem[i] = 8'h00;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    check("req_ready", 32'(req_ready), 32'd1);
    check("resp_valid", 32'(resp_valid), 32'd0);
    issue(1'b0, 1'b0, win_addr(3'd0, 2'd1, 2'd0), '0);
    issue(1'b1, 1'b0, win_addr(3'd0, 2'd1, 2'd0), 32'hcafef00d);
    issue(1'b0, 1'b0, win_addr(3'd0, 2'd1, 2'd0), '0);
    drain();
    report_test(1, "word access");

    issue(1'b1, 1'b0, win_addr(3'd1, 2'd2, 2'd0), 32'h11223344);
    issue(1'b1, 1'b1, win_addr(3'd1, 2'd2, 2'd1), 32'h000000a5);
    issue(1'b0, 1'b0, win_addr(3'd1, 2'd2, 2'd0), '0);
    issue(1'b0, 1'b1, win_addr(3'd1, 2'd2, 2'd1), '0);
    issue(1'b0, 1'b1, win_addr(3'd1, 2'd2, 2'd3), '0);
    drain();
    report_test(2, "byte access");

    // Op bits: write, byte, line[2:0], word[1:0]
    for (int k = 0; k < 200; k++)
    begin
      op  = take_bits(7);
      sub = op[5] ? take_bits(2) : 32'd0;
      d   = op[6] ? take_bits(op[5] ? 8 : 32) : 32'd0;
      issue(op[6], op[5], win_addr(op[4:2], op[1:0], sub[1:0]), d);
    end
    drain();
    report_test(3, "random mix");

    issue(1'b0, 1'b0, win_addr(3'd6, 2'd0, 2'd0), '0);
    drain();
    check_lat = 1'b1;
    for (int w = 0; w < 4; w++)
      issue(1'b0, 1'b0, win_addr(3'd6, 2'(w), 2'd0), '0);
    issue(1'b0, 1'b1, win_addr(3'd6, 2'd3, 2'd2), '0);
    drain();
    check_lat = 1'b0;
    report_test(4, "back-to-back hits");

    // Five lines through four ways, then back in reverse
    for (int l = 0; l < 5; l++)
    begin
      d = take_bits(32);
      issue(1'b1, 1'b0, win_addr(3'(l), 2'd2, 2'd0), d);
    end
    for (int l = 4; l >= 0; l--)
      issue(1'b0, 1'b0, win_addr(3'(l), 2'd2, 2'd0), '0);
    drain();
    report_test(5, "lru eviction");

    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- vlog.f
verilog/cache_pkg.sv
verilog/cache_lookup.sv
verilog/cache_lru.sv
verilog/cache_access.sv
verilog/line_memory.sv
verilog/cache_top.sv
verif/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cache_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vcache_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

grep -qx "Regression passed" sim.log || exit 1
exit 0
